// ==== dv/decode_input.txt ====
// instr_op_rs1_rs2_rd_imm_hasimm in hex; op follows the op_e numbering.
// Register bytes hold the 5-bit index; the last digit is the has_imm flag.
123452b7_0e_00_00_05_12345000_1 // lui x5, 0x12345
fffff517_0f_00_00_0a_fffff000_1 // auipc x10, 0xfffff
ff9ff0ef_10_00_00_01_fffffff8_1 // jal x1, -8
00008067_11_01_00_00_00000000_1 // jalr x0, 0(x1)
fe208ee3_0a_01_02_00_fffffffc_1 // beq x1, x2, -4
0041e863_1b_03_04_00_00000010_1 // bltu x3, x4, 16
ffc12303_14_02_00_06_fffffffc_1 // lw x6, -4(x2)
00844383_15_08_00_07_00000008_1 // lbu x7, 8(x8)
00512623_19_02_05_00_0000000c_1 // sw x5, 12(x2)
fe951f23_18_0a_09_00_fffffffe_1 // sh x9, -2(x10)
fff00093_00_00_00_01_ffffffff_1 // addi x1, x0, -1
40725193_07_04_00_03_00000007_1 // srai x3, x4, 7
01f29293_03_05_00_05_0000001f_1 // slli x5, x5, 31
402081b3_08_01_02_03_00000000_0 // sub x3, x1, x2
407352b3_07_06_07_05_00000000_0 // sra x5, x6, x7
00a4b433_06_09_0a_08_00000000_0 // sltu x8, x9, x10
00004144_14_0a_00_09_00000004_1 // c.lw x9, 4(x10)
0000dfe0_19_0f_08_00_0000007c_1 // c.sw x8, 124(x15)
000012f5_00_05_00_05_fffffffd_1 // c.addi x5, -3
00003fc5_1c_00_00_01_fffffff0_1 // c.jal -16
000071fd_0e_00_00_03_fffff000_1 // c.lui x3, 0xfffff
00008c05_08_08_09_08_00000000_0 // c.sub x8, x9
00008d2d_09_0a_0b_0a_00000000_0 // c.xor x10, x11
00008e55_02_0c_0d_0c_00000000_0 // c.or x12, x13
00008f7d_01_0e_0f_0e_00000000_0 // c.and x14, x15
0000030e_03_06_00_06_00000003_1 // c.slli x6, 3
00008082_11_01_00_00_00000000_0 // c.jr x1
00009282_11_05_00_01_00000000_0 // c.jalr x5
00008192_00_00_04_03_00000000_0 // c.mv x3, x4
00009192_00_03_04_03_00000000_0 // c.add x3, x4
00000000_1f_00_00_00_00000000_0 // all-zero word
00007141_1f_00_00_00_00000000_0 // c.addi16sp, not supported
fe20aee3_1f_00_00_00_00000000_0 // branch with funct3 010
00008005_1f_00_00_00_00000000_0 // c.srli, not supported

// ==== filelist.f ====
hdl/rv_isa_pkg.sv
hdl/dec_pkg.sv
hdl/dec_if.sv
hdl/base_decoder.sv
hdl/rvc_decoder.sv
hdl/decode_out_reg.sv
hdl/instr_decoder_top.sv
dv/decode_out_reg_checker.sv
dv/instr_decoder_tb.sv

// ==== Makefile ====
# Verilator flow for the instruction decoder.
# Example: make sim OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= instr_decoder_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/10ps
PASS_MSG  ?= test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/instr_decoder_tb.sv ====
`timescale 1ns/10ps

module instr_decoder_tb;
    import rv_isa_pkg::*;
    import dec_pkg::*;

    localparam int NUM_VECS   = 34;
    localparam int MAX_CYCLES = 20 * NUM_VECS + 100;

    // instr[99:68], op[67:60], rs1[59:52], rs2[51:44], rd[43:36], imm[35:4], has_imm[3:0].
    typedef logic [99:0] vec_t;

    logic     clk;
    logic     rst;
    logic     in_valid;
    instr_t   in_instr;
    logic     in_ready;
    logic     out_valid;
    op_e      out_op;
    reg_idx_t out_rs1;
    reg_idx_t out_rs2;
    reg_idx_t out_rd;
    imm_t     out_imm;
    logic     out_has_imm;
    logic     out_ready;

    vec_t vecs [0:NUM_VECS-1];
    vec_t exp_q [$];
    int   sent;
    int   accepted;
    int   checked;
    int   cycles;
    logic in_fire;
    logic out_fire;
    logic prev_in_fire;

    instr_decoder_top dut (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_instr    (in_instr),
        .in_ready    (in_ready),
        .out_valid   (out_valid),
        .out_op      (out_op),
        .out_rs1     (out_rs1),
        .out_rs2     (out_rs2),
        .out_rd      (out_rd),
        .out_imm     (out_imm),
        .out_has_imm (out_has_imm),
        .out_ready   (out_ready)
    );

    bind decode_out_reg decode_out_reg_checker u_handshake_checker (
        .clk         (clk),
        .rst         (rst),
        .in_ready    (in_ready),
        .out_valid   (out_valid),
        .out_op      (out_op),
        .out_rs1     (out_rs1),
        .out_rs2     (out_rs2),
        .out_rd      (out_rd),
        .out_imm     (out_imm),
        .out_has_imm (out_has_imm),
        .out_ready   (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ========================================================================
    // Result checks
    // ========================================================================
    task automatic stop_with_failure();
        $display("test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_op(input string field, input op_e got, input op_e exp);
        if (got !== exp) begin
            $display("[FAIL] %0t: %s is %0d, expected %0d", $time, field, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_reg(input string field, input reg_idx_t got, input reg_idx_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t: %s is x%0d, expected x%0d", $time, field, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_imm(input string field, input imm_t got, input imm_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t: %s is %h, expected %h", $time, field, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_flag(input string field, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %0t: %s is %b, expected %b", $time, field, got, exp);
            stop_with_failure();
        end
    endtask

    // ========================================================================
    // Stimulus and monitoring
    // ========================================================================
    task automatic drive_inputs();
        if (in_fire) begin
            sent++;
        end
        if (!in_valid || in_fire) begin // A pending word is held until taken.
            if (sent < NUM_VECS && ($urandom % 4) != 0) begin
                in_valid <= 1'b1;
                in_instr <= vecs[sent][99:68];
            end else begin
                in_valid <= 1'b0;
            end
        end
        out_ready <= ($urandom % 3) != 0;
    endtask

    task automatic watch_handshake();
        vec_t expv;
        in_fire  = in_valid && in_ready;
        out_fire = out_valid && out_ready;
        if (accepted == 0 && out_valid) begin
            $display("out_valid rose before any instruction was accepted");
            stop_with_failure();
        end
        // Right after an accept the register holds that word and nothing older.
        if (prev_in_fire && (!out_valid || exp_q.size() != 1)) begin
            $display("an accepted instruction did not appear one cycle later");
            stop_with_failure();
        end
        if (out_fire) begin
            if (exp_q.size() == 0) begin
                $display("a result came out with no accepted instruction pending");
                stop_with_failure();
            end
            expv = exp_q.pop_front();
            check_op("op", out_op, op_e'(expv[64:60]));
            check_reg("rs1", out_rs1, expv[56:52]);
            check_reg("rs2", out_rs2, expv[48:44]);
            check_reg("rd", out_rd, expv[40:36]);
            check_imm("imm", out_imm, expv[35:4]);
            check_flag("has_imm", out_has_imm, expv[0]);
            checked++;
        end
        if (in_fire) begin
            exp_q.push_back(vecs[sent]);
            accepted++;
        end
        prev_in_fire = in_fire;
    endtask

    initial begin
        void'($urandom(32'hd4b6_e619));
        rst          = 1'b0;
        in_valid     = 1'b0;
        in_instr     = '0;
        out_ready    = 1'b0;
        sent         = 0;
        accepted     = 0;
        checked      = 0;
        cycles       = 0;
        in_fire      = 1'b0;
        out_fire     = 1'b0;
        prev_in_fire = 1'b0;
        $readmemh("dv/decode_input.txt", vecs);
        repeat (3) @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);
        check_flag("out_valid after reset", out_valid, 1'b0);
        check_op("op after reset", out_op, OP_ILLEGAL);
        while (checked < NUM_VECS && cycles < MAX_CYCLES) begin
            @(posedge clk);
            drive_inputs();
            @(negedge clk);
            cycles++;
            watch_handshake();
        end
        if (checked == NUM_VECS && exp_q.size() == 0) begin
            $display("test passed");
            $finish;
        end else begin
            $display("timeout: not all results arrived");
            stop_with_failure();
        end
    end

endmodule

// ==== dv/decode_out_reg_checker.sv ====
`timescale 1ns/10ps

module decode_out_reg_checker (
    input logic                 clk,
    input logic                 rst,
    input logic                 in_ready,
    input logic                 out_valid,
    input dec_pkg::op_e         out_op,
    input rv_isa_pkg::reg_idx_t out_rs1,
    input rv_isa_pkg::reg_idx_t out_rs2,
    input rv_isa_pkg::reg_idx_t out_rd,
    input dec_pkg::imm_t        out_imm,
    input logic                 out_has_imm,
    input logic                 out_ready
);
    import dec_pkg::*;

    assert property (@(posedge clk) !rst |=> !out_valid)
        else $error("out_valid is set in the cycle after reset");

    // A stalled result must hold until the consumer takes it.
    assert property (@(posedge clk) disable iff (!rst)
        out_valid && !out_ready |=> out_valid && $stable(out_op) && $stable(out_rs1)
            && $stable(out_rs2) && $stable(out_rd) && $stable(out_imm)
            && $stable(out_has_imm))
        else $error("outputs changed while the result was stalled");

    assert property (@(posedge clk) in_ready == (!out_valid || out_ready))
        else $error("in_ready does not match the output register state");

    assert property (@(posedge clk) disable iff (!rst)
        out_valid && out_op == OP_ILLEGAL |-> out_rs1 == '0 && out_rs2 == '0
            && out_rd == '0 && out_imm == '0 && !out_has_imm)
        else $error("illegal result carries nonzero fields");

endmodule

// ==== hdl/instr_decoder_top.sv ====
`timescale 1ns/10ps

module instr_decoder_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    input  rv_isa_pkg::instr_t   in_instr,
    output logic                 in_ready,
    output logic                 out_valid,
    output dec_pkg::op_e         out_op,
    output rv_isa_pkg::reg_idx_t out_rs1,
    output rv_isa_pkg::reg_idx_t out_rs2,
    output rv_isa_pkg::reg_idx_t out_rd,
    output dec_pkg::imm_t        out_imm,
    output logic                 out_has_imm,
    input  logic                 out_ready
);

    // ========================================================================
    // Two decoders look at every word in parallel.
    // ========================================================================
    dec_if base_if ();
    dec_if rvc_if ();

    base_decoder u_base_decoder (
        .instr (in_instr),
        .dec   (base_if.producer)
    );

    rvc_decoder u_rvc_decoder (
        .instr (in_instr),
        .dec   (rvc_if.producer)
    );

    decode_out_reg u_decode_out_reg (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .base        (base_if.consumer),
        .rvc         (rvc_if.consumer),
        .out_valid   (out_valid),
        .out_op      (out_op),
        .out_rs1     (out_rs1),
        .out_rs2     (out_rs2),
        .out_rd      (out_rd),
        .out_imm     (out_imm),
        .out_has_imm (out_has_imm),
        .out_ready   (out_ready)
    );

endmodule

// ==== hdl/decode_out_reg.sv ====
`timescale 1ns/10ps

module decode_out_reg (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    output logic                in_ready,
    dec_if.consumer             base,
    dec_if.consumer             rvc,
    output logic                out_valid,
    output dec_pkg::op_e        out_op,
    output rv_isa_pkg::reg_idx_t out_rs1,
    output rv_isa_pkg::reg_idx_t out_rs2,
    output rv_isa_pkg::reg_idx_t out_rd,
    output dec_pkg::imm_t       out_imm,
    output logic                out_has_imm,
    input  logic                out_ready
);
    import rv_isa_pkg::*;
    import dec_pkg::*;

    op_e      sel_op;
    reg_idx_t sel_rs1;
    reg_idx_t sel_rs2;
    reg_idx_t sel_rd;
    imm_t     sel_imm;
    logic     sel_has_imm;
    logic     take;

    assign in_ready = !out_valid || out_ready; // Room when empty or draining this cycle.
    assign take     = in_valid && in_ready;

    always_comb begin
        if (base.hit) begin
            sel_op      = base.op;
            sel_rs1     = base.rs1;
            sel_rs2     = base.rs2;
            sel_rd      = base.rd;
            sel_imm     = base.imm;
            sel_has_imm = base.has_imm;
        end else if (rvc.hit) begin
            sel_op      = rvc.op;
            sel_rs1     = rvc.rs1;
            sel_rs2     = rvc.rs2;
            sel_rd      = rvc.rd;
            sel_imm     = rvc.imm;
            sel_has_imm = rvc.has_imm;
        end else begin
            sel_op      = OP_ILLEGAL;
            sel_rs1     = '0;
            sel_rs2     = '0;
            sel_rd      = '0;
            sel_imm     = '0;
            sel_has_imm = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            out_valid <= 1'b0;
            out_op    <= OP_ILLEGAL;
        end else begin
            out_valid <= take || (out_valid && !out_ready);
            if (take) begin
                out_op <= sel_op;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            out_rs1     <= sel_rs1;
            out_rs2     <= sel_rs2;
            out_rd      <= sel_rd;
            out_imm     <= sel_imm;
            out_has_imm <= sel_has_imm;
        end
    end

endmodule

// ==== hdl/rvc_decoder.sv ====
`timescale 1ns/10ps

module rvc_decoder (
    input  rv_isa_pkg::instr_t instr,
    dec_if.producer            dec
);
    import rv_isa_pkg::*;
    import dec_pkg::*;

    quad_t    quad;
    funct3_t  funct3;
    reg_idx_t rd_full;
    reg_idx_t rs2_full;
    reg_idx_t rs1_p;
    reg_idx_t rs2_p;
    imm_t     imm_mem;
    imm_t     imm_addi;
    imm_t     imm_jal;
    imm_t     imm_lui;
    imm_t     imm_sh;

    assign quad     = instr[1:0];
    assign funct3   = instr[15:13];
    assign rd_full  = instr[11:7];
    assign rs2_full = instr[6:2];
    assign rs1_p    = {2'b00, instr[9:7]} + RVC_REG_BASE;
    assign rs2_p    = {2'b00, instr[4:2]} + RVC_REG_BASE;

    assign imm_mem  = {25'b0, instr[5], instr[12:10], instr[6], 2'b00}; // Word offset.
    assign imm_addi = {{26{instr[12]}}, instr[12], instr[6:2]};
    assign imm_jal  = {{20{instr[12]}}, instr[12], instr[8], instr[10:9], instr[6],
                       instr[7], instr[2], instr[11], instr[5:3], 1'b0};
    assign imm_lui  = {{14{instr[12]}}, instr[12], instr[6:2], 12'b0};
    assign imm_sh   = {26'b0, instr[12], instr[6:2]};

    always_comb begin
        dec.hit     = 1'b0;
        dec.op      = OP_ILLEGAL;
        dec.rs1     = '0;
        dec.rs2     = '0;
        dec.rd      = '0;
        dec.imm     = '0;
        dec.has_imm = 1'b0;
        if (quad == QUAD_C0 && (funct3 == C3_LW || funct3 == C3_SW)) begin
            dec.hit     = 1'b1;
            dec.op      = (funct3 == C3_LW) ? LW : SW;
            dec.rs1     = rs1_p;
            dec.rs2     = (funct3 == C3_SW) ? rs2_p : '0;
            dec.rd      = (funct3 == C3_LW) ? rs2_p : '0;
            dec.imm     = imm_mem;
            dec.has_imm = 1'b1;
        end else if (quad == QUAD_C1) begin
            dec.has_imm = 1'b1;
            case (funct3)
                C3_ADDI: begin
                    dec.hit = 1'b1;
                    dec.op  = ADD;
                    dec.rs1 = rd_full;
                    dec.rd  = rd_full;
                    dec.imm = imm_addi;
                end
                C3_JAL: begin
                    dec.hit = 1'b1;
                    dec.op  = JAL_C;
                    dec.rd  = REG_RA;
                    dec.imm = imm_jal;
                end
                C3_LUI: begin
                    dec.hit = (rd_full != 5'd2); // rd of x2 is the dropped C.ADDI16SP.
                    dec.op  = LUI;
                    dec.rd  = rd_full;
                    dec.imm = imm_lui;
                end
                C3_ALU: begin
                    dec.hit     = (instr[12:10] == 3'b011);
                    dec.rs1     = rs1_p;
                    dec.rs2     = rs2_p;
                    dec.rd      = rs1_p;
                    dec.has_imm = 1'b0;
                    case (instr[6:5])
                        2'b00:   dec.op = SUB;
                        2'b01:   dec.op = XOR;
                        2'b10:   dec.op = OR;
                        default: dec.op = AND;
                    endcase
                end
                default: dec.hit = 1'b0;
            endcase
        end else if (quad == QUAD_C2 && funct3 == C3_SLLI) begin
            dec.hit     = 1'b1;
            dec.op      = SLL;
            dec.rs1     = rd_full;
            dec.rd      = rd_full;
            dec.imm     = imm_sh;
            dec.has_imm = 1'b1;
        end else if (quad == QUAD_C2 && funct3 == C3_JR) begin
            dec.hit = 1'b1;
            if (rs2_full == 5'd0) begin
                dec.op  = JALR;
                dec.rs1 = rd_full;
                dec.rd  = instr[12] ? REG_RA : 5'd0; // C.JALR links and C.JR does not.
            end else begin
                dec.op  = ADD;
                dec.rs1 = instr[12] ? rd_full : 5'd0;
                dec.rs2 = rs2_full;
                dec.rd  = rd_full;
            end
        end
        if (!dec.hit) begin
            dec.op      = OP_ILLEGAL;
            dec.rs1     = '0;
            dec.rs2     = '0;
            dec.rd      = '0;
            dec.imm     = '0;
            dec.has_imm = 1'b0;
        end
    end

endmodule

// ==== hdl/base_decoder.sv ====
`timescale 1ns/10ps

module base_decoder (
    input  rv_isa_pkg::instr_t instr,
    dec_if.producer            dec
);
    import rv_isa_pkg::*;
    import dec_pkg::*;

    opcode_t opcode;
    funct3_t funct3;
    imm_t    imm_i;
    imm_t    imm_s;
    imm_t    imm_b;
    imm_t    imm_u;
    imm_t    imm_j;
    imm_t    imm_sh;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    // ========================================================================
    // Immediate formats
    // ========================================================================
    assign imm_i  = {{20{instr[31]}}, instr[31:20]};
    assign imm_s  = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b  = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u  = {instr[31:12], 12'b0};
    assign imm_j  = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    assign imm_sh = {27'b0, instr[24:20]};

    always_comb begin
        dec.hit     = 1'b0;
        dec.op      = OP_ILLEGAL;
        dec.rs1     = '0;
        dec.rs2     = '0;
        dec.rd      = '0;
        dec.imm     = '0;
        dec.has_imm = 1'b0;
        if (instr[1:0] == QUAD_BASE) begin
            dec.hit = 1'b1;
            case (opcode)
                OPC_LUI, OPC_AUIPC: begin
                    dec.op      = (opcode == OPC_LUI) ? LUI : AUIPC;
                    dec.rd      = instr[11:7];
                    dec.imm     = imm_u;
                    dec.has_imm = 1'b1;
                end
                OPC_JAL: begin
                    dec.op      = JAL;
                    dec.rd      = instr[11:7];
                    dec.imm     = imm_j;
                    dec.has_imm = 1'b1;
                end
                OPC_JALR: begin
                    dec.op      = JALR;
                    dec.hit     = (funct3 == F3_JALR);
                    dec.rs1     = instr[19:15];
                    dec.rd      = instr[11:7];
                    dec.imm     = imm_i;
                    dec.has_imm = 1'b1;
                end
                OPC_BRANCH: begin
                    case (funct3)
                        F3_BEQ:  dec.op = BEQ;
                        F3_BNE:  dec.op = BNE;
                        F3_BLT:  dec.op = BLT;
                        F3_BGE:  dec.op = BGE;
                        F3_BLTU: dec.op = BLTU;
                        F3_BGEU: dec.op = BGEU;
                        default: dec.hit = 1'b0;
                    endcase
                    dec.rs1     = instr[19:15];
                    dec.rs2     = instr[24:20];
                    dec.imm     = imm_b;
                    dec.has_imm = 1'b1;
                end
                OPC_LOAD: begin
                    case (funct3)
                        F3_LB:   dec.op = LB;
                        F3_LH:   dec.op = LH;
                        F3_LW:   dec.op = LW;
                        F3_LBU:  dec.op = LBU;
                        F3_LHU:  dec.op = LHU;
                        default: dec.hit = 1'b0;
                    endcase
                    dec.rs1     = instr[19:15];
                    dec.rd      = instr[11:7];
                    dec.imm     = imm_i;
                    dec.has_imm = 1'b1;
                end
                OPC_STORE: begin
                    case (funct3)
                        F3_SB:   dec.op = SB;
                        F3_SH:   dec.op = SH;
                        F3_SW:   dec.op = SW;
                        default: dec.hit = 1'b0;
                    endcase
                    dec.rs1     = instr[19:15];
                    dec.rs2     = instr[24:20];
                    dec.imm     = imm_s;
                    dec.has_imm = 1'b1;
                end
                OPC_OP_IMM: begin
                    dec.imm = imm_i;
                    case (funct3)
                        F3_ADD:  dec.op = ADD;
                        F3_SLT:  dec.op = SLT;
                        F3_SLTU: dec.op = SLTU;
                        F3_XOR:  dec.op = XOR;
                        F3_OR:   dec.op = OR;
                        F3_AND:  dec.op = AND;
                        F3_SLL: begin
                            dec.op  = SLL;
                            dec.imm = imm_sh;
                        end
                        default: begin
                            dec.op  = instr[30] ? SRA : SRL; // Shift amount kept for both.
                            dec.imm = imm_sh;
                        end
                    endcase
                    dec.rs1     = instr[19:15];
                    dec.rd      = instr[11:7];
                    dec.has_imm = 1'b1;
                end
                OPC_OP: begin
                    case (funct3)
                        F3_ADD:  dec.op = instr[30] ? SUB : ADD;
                        F3_SLL:  dec.op = SLL;
                        F3_SLT:  dec.op = SLT;
                        F3_SLTU: dec.op = SLTU;
                        F3_XOR:  dec.op = XOR;
                        F3_SR:   dec.op = instr[30] ? SRA : SRL;
                        F3_OR:   dec.op = OR;
                        default: dec.op = AND;
                    endcase
                    dec.rs1 = instr[19:15];
                    dec.rs2 = instr[24:20];
                    dec.rd  = instr[11:7];
                end
                default: dec.hit = 1'b0;
            endcase
        end
        if (!dec.hit) begin
            dec.op      = OP_ILLEGAL; // A miss always carries the illegal result.
            dec.rs1     = '0;
            dec.rs2     = '0;
            dec.rd      = '0;
            dec.imm     = '0;
            dec.has_imm = 1'b0;
        end
    end

endmodule

// ==== hdl/dec_if.sv ====
`timescale 1ns/10ps

interface dec_if;
    import rv_isa_pkg::*;
    import dec_pkg::*;

    logic     hit; // The word is of this encoding and was recognised.
    op_e      op;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    imm_t     imm;
    logic     has_imm;

    modport producer (output hit, op, rs1, rs2, rd, imm, has_imm);
    modport consumer (input hit, op, rs1, rs2, rd, imm, has_imm);

endinterface

// ==== hdl/dec_pkg.sv ====
package dec_pkg;

    localparam int XLEN = 32;
    localparam int OP_W = 5;

    typedef logic [XLEN-1:0] imm_t;

    // Operation codes keep the numbering of the existing decoder.
    typedef enum logic [OP_W-1:0] {
        ADD        = 5'd0,
        AND        = 5'd1,
        OR         = 5'd2,
        SLL        = 5'd3,
        SRL        = 5'd4,
        SLT        = 5'd5,
        SLTU       = 5'd6,
        SRA        = 5'd7,
        SUB        = 5'd8,
        XOR        = 5'd9,
        BEQ        = 5'd10,
        BGE        = 5'd11,
        BNE        = 5'd12,
        BGEU       = 5'd13,
        LUI        = 5'd14,
        AUIPC      = 5'd15,
        JAL        = 5'd16,
        JALR       = 5'd17,
        LB         = 5'd18,
        LH         = 5'd19,
        LW         = 5'd20,
        LBU        = 5'd21,
        LHU        = 5'd22,
        SB         = 5'd23,
        SH         = 5'd24,
        SW         = 5'd25,
        BLT        = 5'd26,
        BLTU       = 5'd27,
        JAL_C      = 5'd28,
        OP_ILLEGAL = 5'd31
    } op_e;

endpackage

// ==== hdl/rv_isa_pkg.sv ====
package rv_isa_pkg;

    // ========================================================================
    // Field types
    // ========================================================================
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [1:0]  quad_t;

    // ========================================================================
    // Base encoding
    // ========================================================================
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_OP     = 7'b0110011;

    localparam funct3_t F3_JALR = 3'b000;
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;
    localparam funct3_t F3_LB   = 3'b000;
    localparam funct3_t F3_LH   = 3'b001;
    localparam funct3_t F3_LW   = 3'b010;
    localparam funct3_t F3_LBU  = 3'b100;
    localparam funct3_t F3_LHU  = 3'b101;
    localparam funct3_t F3_SB   = 3'b000;
    localparam funct3_t F3_SH   = 3'b001;
    localparam funct3_t F3_SW   = 3'b010;
    localparam funct3_t F3_ADD  = 3'b000;
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SR   = 3'b101; // SRL or SRA, told apart by bit 30.
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    // ========================================================================
    // Compressed encoding
    // ========================================================================
    localparam quad_t QUAD_C0   = 2'b00;
    localparam quad_t QUAD_C1   = 2'b01;
    localparam quad_t QUAD_C2   = 2'b10;
    localparam quad_t QUAD_BASE = 2'b11;

    localparam funct3_t C3_LW   = 3'b010; // Quadrant 0.
    localparam funct3_t C3_SW   = 3'b110; // Quadrant 0.
    localparam funct3_t C3_ADDI = 3'b000; // Quadrant 1.
    localparam funct3_t C3_JAL  = 3'b001; // Quadrant 1.
    localparam funct3_t C3_LUI  = 3'b011; // Quadrant 1.
    localparam funct3_t C3_ALU  = 3'b100; // Quadrant 1.
    localparam funct3_t C3_SLLI = 3'b000; // Quadrant 2.
    localparam funct3_t C3_JR   = 3'b100; // Quadrant 2.

    localparam reg_idx_t RVC_REG_BASE = 5'd8; // x8 is the first register of the 3-bit fields.
    localparam reg_idx_t REG_RA       = 5'd1;

endpackage
